/* files.f */
rtl/conv_mac_pkg.sv
rtl/rd_request_gen.sv
rtl/rsp_pair.sv
rtl/cmul_stage.sv
rtl/accum_stage.sv
rtl/out_fifo.sv
rtl/wr_request_gen.sv
rtl/conv_mac_top.sv
tb/tb_checker.sv
tb/tb_conv_mac.sv

/* rtl/accum_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// burst accumulator
// sums num_maps consecutive products per element and emits
// one Q1.15 line per burst
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module accum_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [15:0]          num_maps,
  input  logic                 prod_valid,
  input  logic [255:0]         prod_line,
  output logic                 sum_valid,
  output conv_mac_pkg::line_t  sum_line
);

  localparam int elems = conv_mac_pkg::elems;
  localparam int acc_w = 2 * conv_mac_pkg::part_w;

  logic [15:0]      maps_q;
  logic [15:0]      cnt;
  logic             first;
  logic             last;
  logic [acc_w-1:0] acc_re [elems];
  logic [acc_w-1:0] acc_im [elems];
  logic [acc_w-1:0] next_re [elems];
  logic [acc_w-1:0] next_im [elems];

  // first product of a burst loads instead of adding
  always_comb begin
    first = (cnt == 16'd0);
    last  = (cnt == maps_q - 16'd1);
    for (int e = 0; e < elems; e++) begin
      next_re[e] = prod_line[2*acc_w*e +: acc_w] + (first ? '0 : acc_re[e]);
      next_im[e] = prod_line[2*acc_w*e + acc_w +: acc_w] + (first ? '0 : acc_im[e]);
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      for (int e = 0; e < elems; e++) begin
        acc_re[e] <= next_re[e];
        acc_im[e] <= next_im[e];
        // Q2.30 back to Q1.15
        sum_line.elem[e].re <= next_re[e][30:15];
        sum_line.elem[e].im <= next_im[e][30:15];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      maps_q    <= 16'd1;
      cnt       <= 16'd0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && last;
      if (start) begin
        maps_q <= num_maps;
        cnt    <= 16'd0;
      end else if (prod_valid) begin
        cnt <= last ? 16'd0 : cnt + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cmul_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// element-wise complex multiply of an image and a kernel line
// two register stages; products stay full width (Q2.30)
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cmul_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pair_valid,
  input  conv_mac_pkg::line_t  image_line,
  input  conv_mac_pkg::line_t  kernel_line,
  output logic                 prod_valid,
  output logic [255:0]         prod_line
);

  localparam int elems = conv_mac_pkg::elems;
  localparam int prod_w = 2 * conv_mac_pkg::part_w;

  logic               valid_s1;
  logic signed [prod_w-1:0] rr [elems];
  logic signed [prod_w-1:0] ii [elems];
  logic signed [prod_w-1:0] ri [elems];
  logic signed [prod_w-1:0] ir [elems];

  // stage 1 partial products
  always_ff @(posedge clk) begin
    for (int e = 0; e < elems; e++) begin
      rr[e] <= $signed(image_line.elem[e].re) * $signed(kernel_line.elem[e].re);
      ii[e] <= $signed(image_line.elem[e].im) * $signed(kernel_line.elem[e].im);
      ri[e] <= $signed(image_line.elem[e].re) * $signed(kernel_line.elem[e].im);
      ir[e] <= $signed(image_line.elem[e].im) * $signed(kernel_line.elem[e].re);
    end
  end

  // stage 2 combine, wraps at 32 bits
  always_ff @(posedge clk) begin
    for (int e = 0; e < elems; e++) begin
      prod_line[2*prod_w*e +: prod_w]          <= rr[e] - ii[e];
      prod_line[2*prod_w*e + prod_w +: prod_w] <= ri[e] + ir[e];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1   <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      valid_s1   <= pair_valid;
      prod_valid <= valid_s1;
    end
  end

endmodule

`default_nettype wire

/* rtl/conv_mac_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// line geometry, request tags and the line type shared by the
// convolution MAC engine; modules refer to it by scoped names
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package conv_mac_pkg;

  localparam int part_w = 16;
  localparam int elems  = 4;
  localparam int line_w = 128;
  localparam int tag_w  = 2;

  // bit 0 selects kernel, bit 1 stays zero
  localparam logic [tag_w-1:0] tag_image  = 2'b00;
  localparam logic [tag_w-1:0] tag_kernel = 2'b01;

  // one Q1.15 complex element, imaginary part on top
  typedef struct packed {
    logic signed [part_w-1:0] im;
    logic signed [part_w-1:0] re;
  } cplx_t;

  // raw cacheline on the memory side, elements in the datapath
  typedef union packed {
    logic [line_w-1:0]      bits;
    cplx_t [elems-1:0]      elem;
  } line_t;

endpackage

`default_nettype wire

/* rtl/conv_mac_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// convolution MAC engine top level
// read requests -> response pairing -> complex multiply ->
// burst accumulate -> output FIFO -> write requests
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module conv_mac_top #(
  parameter int addr_width      = 58,
  parameter int fifo_depth_bits = 3
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic [addr_width-1:0]           image_base,
  input  logic [addr_width-1:0]           kernel_base,
  input  logic [addr_width-1:0]           dest_base,
  input  logic [15:0]                     num_outputs,
  input  logic [15:0]                     num_maps,
  output logic                            rd_req_en,
  output logic [addr_width-1:0]           rd_req_addr,
  output logic [conv_mac_pkg::tag_w-1:0]  rd_req_tag,
  input  logic                            rd_req_almostfull,
  input  logic                            rd_rsp_valid,
  input  logic [conv_mac_pkg::tag_w-1:0]  rd_rsp_tag,
  input  conv_mac_pkg::line_t             rd_rsp_data,
  output logic                            wr_req_en,
  output logic [addr_width-1:0]           wr_req_addr,
  output conv_mac_pkg::line_t             wr_req_data,
  input  logic                            wr_req_almostfull,
  output logic                            done
);

  logic                 pair_valid;
  conv_mac_pkg::line_t  image_line;
  conv_mac_pkg::line_t  kernel_line;
  logic                 prod_valid;
  logic [255:0]         prod_line;
  logic                 sum_valid;
  conv_mac_pkg::line_t  sum_line;
  logic                 fifo_re;
  conv_mac_pkg::line_t  fifo_dout;
  logic                 fifo_empty;

  rd_request_gen #(
    .addr_width      (addr_width),
    .fifo_depth_bits (fifo_depth_bits)
  ) i_rd_request_gen (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .image_base        (image_base),
    .kernel_base       (kernel_base),
    .num_outputs       (num_outputs),
    .num_maps          (num_maps),
    .rd_req_almostfull (rd_req_almostfull),
    // each written line returns one credit
    .line_retired      (wr_req_en),
    .rd_req_en         (rd_req_en),
    .rd_req_addr       (rd_req_addr),
    .rd_req_tag        (rd_req_tag)
  );

  rsp_pair i_rsp_pair (
    .clk          (clk),
    .reset        (reset),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_tag   (rd_rsp_tag),
    .rd_rsp_data  (rd_rsp_data),
    .pair_valid   (pair_valid),
    .image_line   (image_line),
    .kernel_line  (kernel_line)
  );

  cmul_stage i_cmul_stage (
    .clk         (clk),
    .reset       (reset),
    .pair_valid  (pair_valid),
    .image_line  (image_line),
    .kernel_line (kernel_line),
    .prod_valid  (prod_valid),
    .prod_line   (prod_line)
  );

  accum_stage i_accum_stage (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .num_maps   (num_maps),
    .prod_valid (prod_valid),
    .prod_line  (prod_line),
    .sum_valid  (sum_valid),
    .sum_line   (sum_line)
  );

  out_fifo #(
    .fifo_depth_bits (fifo_depth_bits)
  ) i_out_fifo (
    .clk   (clk),
    .reset (reset),
    .we    (sum_valid),
    .din   (sum_line),
    .re    (fifo_re),
    .dout  (fifo_dout),
    .empty (fifo_empty)
  );

  wr_request_gen #(
    .addr_width (addr_width)
  ) i_wr_request_gen (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .dest_base         (dest_base),
    .num_outputs       (num_outputs),
    .wr_req_almostfull (wr_req_almostfull),
    .fifo_empty        (fifo_empty),
    .fifo_dout         (fifo_dout),
    .fifo_re           (fifo_re),
    .wr_req_en         (wr_req_en),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .done              (done)
  );

endmodule

`default_nettype wire

/* rtl/out_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// synchronous FIFO for output lines
// the head entry sits in the dout register, so data is valid
// in the same cycle as re
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module out_fifo #(
  parameter int fifo_depth_bits = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  conv_mac_pkg::line_t  din,
  input  logic                 re,
  output conv_mac_pkg::line_t  dout,
  output logic                 empty
);

  localparam int depth = 2 ** fifo_depth_bits;

  logic [conv_mac_pkg::line_w-1:0] mem [depth];
  logic [fifo_depth_bits-1:0]      wr_ptr;
  logic [fifo_depth_bits-1:0]      rd_ptr;
  logic [fifo_depth_bits:0]        count;
  logic                            head_valid;
  logic                            load_head;
  logic                            from_mem;
  logic                            bypass;
  logic                            push;

  always_comb begin
    load_head = !head_valid || re;
    from_mem  = load_head && (count != '0);
    // write straight into an empty head
    bypass    = load_head && (count == '0) && we;
    push      = we && !bypass;
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din.bits;
    if (from_mem) begin
      dout.bits <= mem[rd_ptr];
    end else if (bypass) begin
      dout <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (from_mem) rd_ptr <= rd_ptr + 1'b1;
      if (push && !from_mem) begin
        count <= count + 1'b1;
      end else if (!push && from_mem) begin
        count <= count - 1'b1;
      end
      if (load_head) head_valid <= from_mem || bypass;
    end
  end

  assign empty = !head_valid;

endmodule

`default_nettype wire

/* rtl/rd_request_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// read request generator
// latches a job on start and issues image/kernel request pairs,
// one group of num_maps pairs per output line, bounded by a
// credit count of lines not yet written back
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rd_request_gen #(
  parameter int addr_width      = 58,
  parameter int fifo_depth_bits = 3
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  logic [addr_width-1:0]            image_base,
  input  logic [addr_width-1:0]            kernel_base,
  input  logic [15:0]                      num_outputs,
  input  logic [15:0]                      num_maps,
  input  logic                             rd_req_almostfull,
  input  logic                             line_retired,
  output logic                             rd_req_en,
  output logic [addr_width-1:0]            rd_req_addr,
  output logic [conv_mac_pkg::tag_w-1:0]   rd_req_tag
);

  typedef enum logic [1:0] {st_idle, st_image, st_kernel, st_finished} state_t;

  localparam logic [fifo_depth_bits:0] credit_max = {1'b1, {fifo_depth_bits{1'b0}}};

  state_t                  state;
  logic [addr_width-1:0]   img_addr;
  logic [addr_width-1:0]   ker_addr;
  logic [15:0]             maps_q;
  logic [15:0]             outputs_q;
  logic [15:0]             pair_cnt;
  logic [15:0]             group_cnt;
  logic [fifo_depth_bits:0] credit;
  logic                    accept_start;
  logic                    issue_image;
  logic                    issue_kernel;
  logic                    open_group;
  logic                    last_pair;
  logic                    last_group;

  always_comb begin
    accept_start = start && (state == st_idle || state == st_finished);
    // a new group needs a free output slot
    issue_image  = (state == st_image) && !rd_req_almostfull &&
                   (pair_cnt != 16'd0 || credit < credit_max);
    issue_kernel = (state == st_kernel) && !rd_req_almostfull;
    open_group   = issue_image && (pair_cnt == 16'd0);
    last_pair    = (pair_cnt == maps_q - 16'd1);
    last_group   = (group_cnt == outputs_q - 16'd1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      rd_req_en <= 1'b0;
      pair_cnt  <= 16'd0;
      group_cnt <= 16'd0;
    end else begin
      rd_req_en <= issue_image || issue_kernel;
      case (state)
        st_idle, st_finished: begin
          if (start) begin
            state     <= st_image;
            pair_cnt  <= 16'd0;
            group_cnt <= 16'd0;
          end
        end
        st_image: begin
          if (issue_image) begin
            state <= st_kernel;
          end
        end
        st_kernel: begin
          if (issue_kernel) begin
            if (!last_pair) begin
              pair_cnt <= pair_cnt + 16'd1;
              state    <= st_image;
            end else begin
              pair_cnt <= 16'd0;
              if (last_group) begin
                state <= st_finished;
              end else begin
                group_cnt <= group_cnt + 16'd1;
                state     <= st_image;
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // job fields, address stepping and request payload
  always_ff @(posedge clk) begin
    if (accept_start) begin
      img_addr  <= image_base;
      ker_addr  <= kernel_base;
      maps_q    <= num_maps;
      outputs_q <= num_outputs;
    end else begin
      if (issue_image) img_addr <= img_addr + 1'b1;
      if (issue_kernel) ker_addr <= ker_addr + 1'b1;
    end
    if (issue_image) begin
      rd_req_addr <= img_addr;
      rd_req_tag  <= conv_mac_pkg::tag_image;
    end else if (issue_kernel) begin
      rd_req_addr <= ker_addr;
      rd_req_tag  <= conv_mac_pkg::tag_kernel;
    end
  end

  // output lines opened but not yet written
  always_ff @(posedge clk) begin
    if (reset) begin
      credit <= '0;
    end else if (open_group && !line_retired) begin
      credit <= credit + 1'b1;
    end else if (!open_group && line_retired) begin
      credit <= credit - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/rsp_pair.sv */
// ~~~~~~~~~~~~~~~~~~~~
// pairs in-order read responses by tag
// an image line waits here until its kernel line arrives
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rsp_pair (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            rd_rsp_valid,
  input  logic [conv_mac_pkg::tag_w-1:0]  rd_rsp_tag,
  input  conv_mac_pkg::line_t             rd_rsp_data,
  output logic                            pair_valid,
  output conv_mac_pkg::line_t             image_line,
  output conv_mac_pkg::line_t             kernel_line
);

  logic is_image;
  logic is_kernel;

  assign is_image  = rd_rsp_valid && (rd_rsp_tag == conv_mac_pkg::tag_image);
  assign is_kernel = rd_rsp_valid && (rd_rsp_tag == conv_mac_pkg::tag_kernel);

  // image stays put until the next image response,
  // which comes no earlier than the cycle pair_valid is up
  always_ff @(posedge clk) begin
    if (is_image) image_line <= rd_rsp_data;
    if (is_kernel) kernel_line <= rd_rsp_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= is_kernel;
    end
  end

endmodule

`default_nettype wire

/* rtl/wr_request_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// write request generator
// drains the output FIFO into writes at consecutive addresses
// and flags done after the last line of the job
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module wr_request_gen #(
  parameter int addr_width = 58
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [addr_width-1:0] dest_base,
  input  logic [15:0]           num_outputs,
  input  logic                  wr_req_almostfull,
  input  logic                  fifo_empty,
  input  conv_mac_pkg::line_t   fifo_dout,
  output logic                  fifo_re,
  output logic                  wr_req_en,
  output logic [addr_width-1:0] wr_req_addr,
  output conv_mac_pkg::line_t   wr_req_data,
  output logic                  done
);

  logic [addr_width-1:0] cur_addr;
  logic [15:0]           outputs_q;
  logic [15:0]           wr_cnt;

  assign fifo_re = !fifo_empty && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (start) begin
      cur_addr <= dest_base;
    end else if (fifo_re) begin
      cur_addr <= cur_addr + 1'b1;
    end
    if (fifo_re) begin
      wr_req_addr <= cur_addr;
      wr_req_data <= fifo_dout;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      outputs_q <= 16'd1;
      wr_cnt    <= 16'd0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= fifo_re;
      if (start) begin
        outputs_q <= num_outputs;
        wr_cnt    <= 16'd0;
        done      <= 1'b0;
      end else if (wr_req_en) begin
        wr_cnt <= wr_cnt + 16'd1;
        if (wr_cnt == outputs_q - 16'd1) done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, and scan the log for the failure status
verilator --binary --timing -Wno-fatal --top-module tb_conv_mac -f files.f -o sim_conv_mac \
  && ./obj_dir/sim_conv_mac > sim.log 2>&1 \
  ; cat sim.log \
  && ! grep -q "STATUS: FAIL" sim.log \
  && grep -q "STATUS: PASS" sim.log \
  || { echo "simulation did not pass"; exit 1; }

/* tb/conv_mac_golden.hex */
// word 0 test count; words 1-6 descriptors as 16-bit fields:
// image_base kernel_base dest_base num_outputs num_maps rd_af wr_af exp_offset
00000000_00000000_00000000_00000006
0007_0008_0100_0001_0001_0000_0000_0035
000d_0021_0200_0003_0004_0000_0000_0036
000d_0021_0300_0003_0004_0001_0000_0036
000d_0021_0400_0014_0001_0000_0001_0039
0009_000b_0500_0001_0002_0000_0000_004d
000d_0021_0600_0003_0004_0001_0001_0036
// words 7-8 single product image and kernel
40000000_00004000_1000e000_10002000
40000000_00004000_20004000_20004000
// words 9-10 full-scale images, 11-12 kernels
0000c000_80000000_00008000_80008000
0000c000_00007fff_00008000_00007fff
00004000_80000000_00008000_80008000
00004000_00008000_00007fff_00007fff
// words 13-32 image lines, element e = n*0x100 + e*0x20
01600160_01400140_01200120_01000100
02600260_02400240_02200220_02000200
03600360_03400340_03200320_03000300
04600460_04400440_04200420_04000400
05600560_05400540_05200520_05000500
06600660_06400640_06200620_06000600
07600760_07400740_07200720_07000700
08600860_08400840_08200820_08000800
09600960_09400940_09200920_09000900
0a600a60_0a400a40_0a200a20_0a000a00
0b600b60_0b400b40_0b200b20_0b000b00
0c600c60_0c400c40_0c200c20_0c000c00
0d600d60_0d400d40_0d200d20_0d000d00
0e600e60_0e400e40_0e200e20_0e000e00
0f600f60_0f400f40_0f200f20_0f000f00
10601060_10401040_10201020_10001000
11601160_11401140_11201120_11001100
12601260_12401240_12201220_12001200
13601360_13401340_13201320_13001300
14601460_14401440_14201420_14001400
// words 33-52 kernel lines of 0.5
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
00004000_00004000_00004000_00004000
// word 53 single product, 54-56 bursts of four
0000e000_00002000_0000ec00_10000c00
05c005c0_05800580_05400540_05000500
0dc00dc0_0d800d80_0d400d40_0d000d00
15c015c0_15801580_15401540_15001500
// words 57-76 image lines halved
00b000b0_00a000a0_00900090_00800080
01300130_01200120_01100110_01000100
01b001b0_01a001a0_01900190_01800180
02300230_02200220_02100210_02000200
02b002b0_02a002a0_02900290_02800280
03300330_03200320_03100310_03000300
03b003b0_03a003a0_03900390_03800380
04300430_04200420_04100410_04000400
04b004b0_04a004a0_04900490_04800480
05300530_05200520_05100510_05000500
05b005b0_05a005a0_05900590_05800580
06300630_06200620_06100610_06000600
06b006b0_06a006a0_06900690_06800680
07300730_07200720_07100710_07000700
07b007b0_07a007a0_07900790_07800780
08300830_08200820_08100810_08000800
08b008b0_08a008a0_08900890_08800880
09300930_09200920_09100910_09000900
09b009b0_09a009a0_09900990_09800980
0a300a30_0a200a20_0a100a10_0a000a00
// word 77 wrapped full-scale sum
0000c000_00000001_00000001_00007ffe

/* tb/tb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// write-side checker for the convolution MAC testbench
// compares each write with the golden line, watches the
// almost-full rules and done, prints one line per test
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_checker #(
  parameter int aw = 58
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 done,
  input  logic                 rd_req_en,
  input  logic                 rd_req_almostfull,
  input  logic                 wr_req_en,
  input  logic                 wr_req_almostfull,
  input  logic [aw-1:0]        wr_req_addr,
  input  conv_mac_pkg::line_t  wr_req_data,
  input  logic [aw-1:0]        dest_base,
  input  int                   test_num,
  input  logic [15:0]          exp_off,
  input  logic [15:0]          exp_count,
  output int                   passed,
  output int                   failed,
  output int                   errors
);

  logic [127:0] gold [128];
  int           wr_cnt;
  int           test_errs;
  logic         active;
  logic         rd_af_q;
  logic         wr_af_q;

  initial begin
    $readmemh("tb/conv_mac_golden.hex", gold);
    passed    = 0;
    failed    = 0;
    errors    = 0;
    wr_cnt    = 0;
    test_errs = 0;
    active    = 1'b0;
    rd_af_q   = 1'b0;
    wr_af_q   = 1'b0;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t: test %0d: %s", $time, test_num, msg);
    errors    = errors + 1;
    test_errs = test_errs + 1;
  endtask

  // outputs are sampled before this edge updates them
  always @(posedge clk) begin
    logic [aw-1:0] exp_addr;
    logic [127:0]  exp_data;
    if (reset) begin
      rd_af_q = 1'b0;
      wr_af_q = 1'b0;
    end else begin
      if (rd_req_en && rd_af_q) report_error("read issued right after rd_req_almostfull");
      if (wr_req_en && wr_af_q) report_error("write issued right after wr_req_almostfull");
      if (start) begin
        wr_cnt    = 0;
        test_errs = 0;
        active    = 1'b1;
      end else begin
        if (wr_req_en) begin
          if (!active || wr_cnt >= int'(exp_count)) begin
            report_error("write request beyond the end of the job");
          end else begin
            exp_addr = dest_base + aw'(wr_cnt);
            exp_data = gold[int'(exp_off) + wr_cnt];
            if (wr_req_addr !== exp_addr) begin
              report_error($sformatf("line %0d address %h, expected %h",
                                     wr_cnt, wr_req_addr, exp_addr));
            end
            if (wr_req_data.bits !== exp_data) begin
              report_error($sformatf("line %0d data %h, expected %h",
                                     wr_cnt, wr_req_data.bits, exp_data));
            end
          end
          wr_cnt = wr_cnt + 1;
        end
        if (active && done) begin
          if (wr_cnt != int'(exp_count)) begin
            report_error($sformatf("done after %0d of %0d lines", wr_cnt, exp_count));
          end
          if (test_errs == 0) begin
            passed = passed + 1;
            $display("test %0d: pass, %0d lines", test_num, wr_cnt);
          end else begin
            failed = failed + 1;
            $display("test %0d: fail, %0d errors", test_num, test_errs);
          end
          active = 1'b0;
        end
      end
      rd_af_q = rd_req_almostfull;
      wr_af_q = wr_req_almostfull;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_conv_mac.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench top for the convolution MAC engine
// loads jobs, memory image and expected lines from the golden
// file, models an in-order memory with random latency and
// random almost-full, and runs each job start to done
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_conv_mac;

  localparam int aw = 58;
  localparam int gold_words = 128;

  logic                   clk;
  logic                   reset;
  logic                   start;
  logic [aw-1:0]          image_base;
  logic [aw-1:0]          kernel_base;
  logic [aw-1:0]          dest_base;
  logic [15:0]            num_outputs;
  logic [15:0]            num_maps;
  logic                   rd_req_en;
  logic [aw-1:0]          rd_req_addr;
  logic [1:0]             rd_req_tag;
  logic                   rd_req_almostfull;
  logic                   rd_rsp_valid;
  logic [1:0]             rd_rsp_tag;
  conv_mac_pkg::line_t    rd_rsp_data;
  logic                   wr_req_en;
  logic [aw-1:0]          wr_req_addr;
  conv_mac_pkg::line_t    wr_req_data;
  logic                   wr_req_almostfull;
  logic                   done;

  logic [127:0] gold [gold_words];
  logic [31:0]  lfsr;
  int           cycle;
  int           cycle_limit;
  int           last_due;
  logic         rd_af_mode;
  logic         wr_af_mode;
  int           test_num;
  logic [15:0]  exp_off;
  logic [15:0]  exp_count;
  int           passed;
  int           failed;
  int           errors;

  // outstanding reads with the oldest first
  int            rsp_due [$];
  logic [aw-1:0] rsp_addr [$];
  logic [1:0]    rsp_tag [$];

  conv_mac_top #(
    .addr_width      (aw),
    .fifo_depth_bits (3)
  ) i_conv_mac_top (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .image_base        (image_base),
    .kernel_base       (kernel_base),
    .dest_base         (dest_base),
    .num_outputs       (num_outputs),
    .num_maps          (num_maps),
    .rd_req_en         (rd_req_en),
    .rd_req_addr       (rd_req_addr),
    .rd_req_tag        (rd_req_tag),
    .rd_req_almostfull (rd_req_almostfull),
    .rd_rsp_valid      (rd_rsp_valid),
    .rd_rsp_tag        (rd_rsp_tag),
    .rd_rsp_data       (rd_rsp_data),
    .wr_req_en         (wr_req_en),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .wr_req_almostfull (wr_req_almostfull),
    .done              (done)
  );

  tb_checker #(
    .aw (aw)
  ) i_tb_checker (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .done              (done),
    .rd_req_en         (rd_req_en),
    .rd_req_almostfull (rd_req_almostfull),
    .wr_req_en         (wr_req_en),
    .wr_req_almostfull (wr_req_almostfull),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .dest_base         (dest_base),
    .test_num          (test_num),
    .exp_off           (exp_off),
    .exp_count         (exp_count),
    .passed            (passed),
    .failed            (failed),
    .errors            (errors)
  );

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > cycle_limit) begin
      $display("timeout after %0d cycles, test %0d never raised done", cycle, test_num);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // in-order memory model answering 1 to 8 cycles after the request
  always @(posedge clk) begin
    int            due;
    logic          req;
    logic [aw-1:0] req_addr;
    logic [1:0]    req_tag;
    req      = !reset && rd_req_en;
    req_addr = rd_req_addr;
    req_tag  = rd_req_tag;
    #2;
    // cycle already counts this edge
    if (req) begin
      due = cycle;
      for (int i = 0; i < 3; i++) begin
        if (lfsr_bit()) due = due + (1 << i);
      end
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_due.push_back(due);
      rsp_addr.push_back(req_addr);
      rsp_tag.push_back(req_tag);
    end
    if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
      rd_rsp_valid     = 1'b1;
      rd_rsp_tag       = rsp_tag[0];
      rd_rsp_data.bits = gold[rsp_addr[0][6:0]];
      void'(rsp_due.pop_front());
      void'(rsp_addr.pop_front());
      void'(rsp_tag.pop_front());
    end else begin
      rd_rsp_valid = 1'b0;
    end
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    if (rd_af_mode) rd_req_almostfull = lfsr_bit();
    if (wr_af_mode) wr_req_almostfull = lfsr_bit();
  end

  initial begin
    int n_tests;
    int total;
    logic [127:0] d;
    reset             = 1'b1;
    start             = 1'b0;
    image_base        = '0;
    kernel_base       = '0;
    dest_base         = '0;
    num_outputs       = 16'd1;
    num_maps          = 16'd1;
    rd_req_almostfull = 1'b0;
    rd_rsp_valid      = 1'b0;
    rd_rsp_tag        = 2'b00;
    rd_rsp_data       = '0;
    wr_req_almostfull = 1'b0;
    rd_af_mode        = 1'b0;
    wr_af_mode        = 1'b0;
    test_num          = 0;
    exp_off           = '0;
    exp_count         = '0;
    lfsr              = 32'h64287a49;
    cycle             = 0;
    last_due          = 0;
    cycle_limit       = 1000000;
    $readmemh("tb/conv_mac_golden.hex", gold);
    n_tests = int'(gold[0][31:0]);
    total = 0;
    for (int t = 1; t <= n_tests; t++) begin
      total = total + int'(gold[t][79:64]) * int'(gold[t][63:48]);
    end
    cycle_limit = 200 + 40 * total;

    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    for (int t = 1; t <= n_tests; t++) begin
      d = gold[t];
      @(posedge clk);
      #2;
      image_base  = aw'(d[127:112]);
      kernel_base = aw'(d[111:96]);
      dest_base   = aw'(d[95:80]);
      num_outputs = d[79:64];
      num_maps    = d[63:48];
      rd_af_mode  = d[32];
      wr_af_mode  = d[16];
      exp_off     = d[15:0];
      exp_count   = d[79:64];
      test_num    = t;
      start       = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      do @(posedge clk); while (!done);
      // let the checker close the test first
      repeat (2) @(posedge clk);
    end
    rd_af_mode = 1'b0;
    wr_af_mode = 1'b0;

    $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0 && failed == 0 && passed == n_tests) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
